// File: design/soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// address map, END is exclusive
`define SRAM_BASE  32'h8000_0000
`define SRAM_END   32'h8000_1000
`define UART_BASE  32'h1000_0000
`define UART_END   32'h1000_0010
`define CLINT_BASE 32'h0200_0000
`define CLINT_END  32'h0200_0010

// 4 KiB window
`define SRAM_DEPTH_WORDS 1024

`define UART_CLKS_PER_BIT 4

`endif

// File: design/soc_pkg.sv
package soc_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axil_resp_e;

  typedef enum logic [2:0] {
    XBAR_IDLE,
    XBAR_SRAM_R,
    XBAR_UART_R,
    XBAR_CLINT_R,
    XBAR_SRAM_W,
    XBAR_UART_W,
    XBAR_CLINT_W,
    XBAR_ERR     // unmapped address, answered locally
  } xbar_state_e;

  // 64-bit timer word, seen whole or as two bus-sized halves
  typedef union packed {
    logic [63:0] full;
    struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
    } half;
  } timer_word_u;

endpackage

// File: design/axil_if.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

interface axil_if;
  logic [`AXIL_ADDR_W-1:0] araddr;
  logic                    arvalid;
  logic                    arready;
  logic [`AXIL_DATA_W-1:0] rdata;
  soc_pkg::axil_resp_e     rresp;
  logic                    rvalid;
  logic                    rready;
  logic [`AXIL_ADDR_W-1:0] awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [`AXIL_DATA_W-1:0] wdata;
  logic                    wvalid;
  logic                    wready;
  soc_pkg::axil_resp_e     bresp;
  logic                    bvalid;
  logic                    bready;

  modport master (
    output araddr, arvalid, rready, awaddr, awvalid, wdata, wvalid, bready,
    input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

  modport slave (
    input  araddr, arvalid, rready, awaddr, awvalid, wdata, wvalid, bready,
    output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

endinterface

// File: design/axil_xbar.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

module axil_xbar (
  input  logic  clk,
  input  logic  rst,
  axil_if.slave  cpu_s,
  axil_if.master sram_m,
  axil_if.master uart_m,
  axil_if.master clint_m
);

  soc_pkg::xbar_state_e state_q, state_nx;
  logic [2:0] rd_hot, wr_hot;  // clint, uart, sram
  logic err_st, err_rd_q, err_done_q, err_ar_rdy, err_w_rdy, err_accept;
  logic r_hs, b_hs;

  function automatic soc_pkg::xbar_state_e decode(input logic [`AXIL_ADDR_W-1:0] addr,
                                                  input logic rd);
    if (addr >= `SRAM_BASE && addr < `SRAM_END)
      return rd ? soc_pkg::XBAR_SRAM_R : soc_pkg::XBAR_SRAM_W;
    if (addr >= `UART_BASE && addr < `UART_END)
      return rd ? soc_pkg::XBAR_UART_R : soc_pkg::XBAR_UART_W;
    if (addr >= `CLINT_BASE && addr < `CLINT_END)
      return rd ? soc_pkg::XBAR_CLINT_R : soc_pkg::XBAR_CLINT_W;
    return soc_pkg::XBAR_ERR;
  endfunction

  assign rd_hot = {state_q == soc_pkg::XBAR_CLINT_R, state_q == soc_pkg::XBAR_UART_R,
                   state_q == soc_pkg::XBAR_SRAM_R};
  assign wr_hot = {state_q == soc_pkg::XBAR_CLINT_W, state_q == soc_pkg::XBAR_UART_W,
                   state_q == soc_pkg::XBAR_SRAM_W};

  // local DECERR responder
  assign err_st     = state_q == soc_pkg::XBAR_ERR;
  assign err_ar_rdy = err_st && err_rd_q && !err_done_q;
  assign err_w_rdy  = err_st && !err_rd_q && !err_done_q && cpu_s.awvalid && cpu_s.wvalid;
  assign err_accept = (err_ar_rdy && cpu_s.arvalid) || err_w_rdy;

  // only the selected slave sees the CPU
  assign sram_m.araddr   = rd_hot[0] ? cpu_s.araddr : '0;
  assign sram_m.arvalid  = rd_hot[0] && cpu_s.arvalid;
  assign sram_m.rready   = rd_hot[0] && cpu_s.rready;
  assign sram_m.awaddr   = wr_hot[0] ? cpu_s.awaddr : '0;
  assign sram_m.awvalid  = wr_hot[0] && cpu_s.awvalid;
  assign sram_m.wdata    = wr_hot[0] ? cpu_s.wdata : '0;
  assign sram_m.wvalid   = wr_hot[0] && cpu_s.wvalid;
  assign sram_m.bready   = wr_hot[0] && cpu_s.bready;
  assign uart_m.araddr   = rd_hot[1] ? cpu_s.araddr : '0;
  assign uart_m.arvalid  = rd_hot[1] && cpu_s.arvalid;
  assign uart_m.rready   = rd_hot[1] && cpu_s.rready;
  assign uart_m.awaddr   = wr_hot[1] ? cpu_s.awaddr : '0;
  assign uart_m.awvalid  = wr_hot[1] && cpu_s.awvalid;
  assign uart_m.wdata    = wr_hot[1] ? cpu_s.wdata : '0;
  assign uart_m.wvalid   = wr_hot[1] && cpu_s.wvalid;
  assign uart_m.bready   = wr_hot[1] && cpu_s.bready;
  assign clint_m.araddr  = rd_hot[2] ? cpu_s.araddr : '0;
  assign clint_m.arvalid = rd_hot[2] && cpu_s.arvalid;
  assign clint_m.rready  = rd_hot[2] && cpu_s.rready;
  assign clint_m.awaddr  = wr_hot[2] ? cpu_s.awaddr : '0;
  assign clint_m.awvalid = wr_hot[2] && cpu_s.awvalid;
  assign clint_m.wdata   = wr_hot[2] ? cpu_s.wdata : '0;
  assign clint_m.wvalid  = wr_hot[2] && cpu_s.wvalid;
  assign clint_m.bready  = wr_hot[2] && cpu_s.bready;

  // one-hot and-or of the selected slave back to the CPU
  assign cpu_s.arready = |(rd_hot & {clint_m.arready, uart_m.arready, sram_m.arready}) ||
                         err_ar_rdy;
  assign cpu_s.rvalid  = |(rd_hot & {clint_m.rvalid, uart_m.rvalid, sram_m.rvalid}) ||
                         (err_st && err_rd_q && err_done_q);
  assign cpu_s.rdata   = ({`AXIL_DATA_W{rd_hot[0]}} & sram_m.rdata) |
                         ({`AXIL_DATA_W{rd_hot[1]}} & uart_m.rdata) |
                         ({`AXIL_DATA_W{rd_hot[2]}} & clint_m.rdata);
  assign cpu_s.rresp   = (err_st && err_rd_q) ? soc_pkg::RESP_DECERR :
                         soc_pkg::axil_resp_e'(({2{rd_hot[0]}} & sram_m.rresp) |
                                               ({2{rd_hot[1]}} & uart_m.rresp) |
                                               ({2{rd_hot[2]}} & clint_m.rresp));
  assign cpu_s.awready = |(wr_hot & {clint_m.awready, uart_m.awready, sram_m.awready}) ||
                         err_w_rdy;
  assign cpu_s.wready  = |(wr_hot & {clint_m.wready, uart_m.wready, sram_m.wready}) ||
                         err_w_rdy;
  assign cpu_s.bvalid  = |(wr_hot & {clint_m.bvalid, uart_m.bvalid, sram_m.bvalid}) ||
                         (err_st && !err_rd_q && err_done_q);
  assign cpu_s.bresp   = (err_st && !err_rd_q) ? soc_pkg::RESP_DECERR :
                         soc_pkg::axil_resp_e'(({2{wr_hot[0]}} & sram_m.bresp) |
                                               ({2{wr_hot[1]}} & uart_m.bresp) |
                                               ({2{wr_hot[2]}} & clint_m.bresp));

  assign r_hs = cpu_s.rvalid && cpu_s.rready;
  assign b_hs = cpu_s.bvalid && cpu_s.bready;

  always_comb begin
    state_nx = state_q;
    if (state_q == soc_pkg::XBAR_IDLE) begin
      if (cpu_s.arvalid) state_nx = decode(cpu_s.araddr, 1'b1);  // reads first
      else if (cpu_s.awvalid) state_nx = decode(cpu_s.awaddr, 1'b0);
    end else if (r_hs || b_hs) begin
      state_nx = soc_pkg::XBAR_IDLE;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q    <= soc_pkg::XBAR_IDLE;
      err_rd_q   <= 1'b0;
      err_done_q <= 1'b0;
    end else begin
      state_q <= state_nx;
      if (state_q == soc_pkg::XBAR_IDLE) err_rd_q <= cpu_s.arvalid;
      if (!err_st) err_done_q <= 1'b0;
      else if (err_accept) err_done_q <= 1'b1;  // address (and data) taken
    end
  end

  // no slave still holds a response once the crossbar is back in idle
  a_idle_quiet: assert property (@(posedge clk) disable iff (!rst)
    state_q == soc_pkg::XBAR_IDLE |-> !(sram_m.rvalid || sram_m.bvalid ||
      uart_m.rvalid || uart_m.bvalid || clint_m.rvalid || clint_m.bvalid));

  // a wait state ends only on the response handshake of its own direction
  a_hold_wait: assert property (@(posedge clk) disable iff (!rst)
    (state_q != soc_pkg::XBAR_IDLE) && !((|rd_hot || (err_st && err_rd_q)) ? r_hs : b_hs)
    |=> state_q == $past(state_q));

endmodule

// File: design/axil_sram.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

module axil_sram (
  input  logic clk,
  input  logic rst,
  axil_if.slave bus_s
);

  localparam int IDX_W = $clog2(`SRAM_DEPTH_WORDS);

  logic [`AXIL_DATA_W-1:0] mem [`SRAM_DEPTH_WORDS];
  logic [`AXIL_DATA_W-1:0] rdata_q;
  logic [IDX_W-1:0]        rd_idx, wr_idx;
  logic rvalid_q, bvalid_q, rd_go, wr_go;

  // base is window aligned, so the low address bits are the offset
  assign rd_idx = bus_s.araddr[IDX_W+1:2];
  assign wr_idx = bus_s.awaddr[IDX_W+1:2];
  assign rd_go  = bus_s.arvalid && !rvalid_q;
  assign wr_go  = bus_s.awvalid && bus_s.wvalid && !bvalid_q;

  assign bus_s.arready = !rvalid_q;       // idle phase
  assign bus_s.rdata   = rdata_q;
  assign bus_s.rresp   = soc_pkg::RESP_OKAY;
  assign bus_s.rvalid  = rvalid_q;
  assign bus_s.awready = wr_go;
  assign bus_s.wready  = wr_go;
  assign bus_s.bresp   = soc_pkg::RESP_OKAY;
  assign bus_s.bvalid  = bvalid_q;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (rd_go) rvalid_q <= 1'b1;
      else if (bus_s.rready) rvalid_q <= 1'b0;
      if (wr_go) bvalid_q <= 1'b1;
      else if (bus_s.bready) bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) rdata_q <= mem[rd_idx];
    if (wr_go) mem[wr_idx] <= bus_s.wdata;
  end

  a_r_hold: assert property (@(posedge clk) disable iff (!rst)
    bus_s.rvalid && !bus_s.rready |=> bus_s.rvalid && $stable(bus_s.rdata));

endmodule

// File: design/axil_uart.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

module axil_uart (
  input  logic  clk,
  input  logic  rst,
  axil_if.slave bus_s,
  output logic  uart_tx_o
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);

  logic [9:0]              shift_q;  // stop, data, start
  logic [3:0]              bit_cnt_q;
  logic [CNT_W-1:0]        clk_cnt_q;
  logic [`AXIL_DATA_W-1:0] rdata_q;
  soc_pkg::axil_resp_e     bresp_q;
  logic busy_q, rvalid_q, bvalid_q, rd_go, wr_go, tx_wr, load;

  assign rd_go = bus_s.arvalid && !rvalid_q;
  assign wr_go = bus_s.awvalid && bus_s.wvalid && !bvalid_q;
  assign tx_wr = bus_s.awaddr[3:2] == 2'd0;    // TXDATA
  assign load  = wr_go && tx_wr && !busy_q;
  assign uart_tx_o = shift_q[0];

  assign bus_s.arready = !rvalid_q;
  assign bus_s.rdata   = rdata_q;
  assign bus_s.rresp   = soc_pkg::RESP_OKAY;
  assign bus_s.rvalid  = rvalid_q;
  assign bus_s.awready = wr_go;
  assign bus_s.wready  = wr_go;
  assign bus_s.bresp   = bresp_q;
  assign bus_s.bvalid  = bvalid_q;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (rd_go) rvalid_q <= 1'b1;
      else if (bus_s.rready) rvalid_q <= 1'b0;
      if (wr_go) bvalid_q <= 1'b1;
      else if (bus_s.bready) bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) rdata_q <= (bus_s.araddr[3:2] == 2'd1) ? `AXIL_DATA_W'(busy_q) : '0;
    if (wr_go) bresp_q <= (tx_wr && busy_q) ? soc_pkg::RESP_SLVERR : soc_pkg::RESP_OKAY;
  end

  // 8N1 serializer, ones shift in behind the frame so the line idles high
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      shift_q   <= '1;
      busy_q    <= 1'b0;
      bit_cnt_q <= '0;
      clk_cnt_q <= '0;
    end else if (load) begin
      shift_q   <= {1'b1, bus_s.wdata[7:0], 1'b0};
      busy_q    <= 1'b1;
      bit_cnt_q <= '0;
      clk_cnt_q <= '0;
    end else if (busy_q) begin
      if (clk_cnt_q == CNT_LAST) begin
        clk_cnt_q <= '0;
        shift_q   <= {1'b1, shift_q[9:1]};
        if (bit_cnt_q == 4'd9) busy_q <= 1'b0;  // stop bit done
        else bit_cnt_q <= bit_cnt_q + 4'd1;
      end else begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
    end
  end

  a_no_reload: assert property (@(posedge clk) disable iff (!rst)
    busy_q |=> !busy_q || (bit_cnt_q >= $past(bit_cnt_q)));

endmodule

// File: design/axil_clint.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

module axil_clint (
  input  logic  clk,
  input  logic  rst,
  axil_if.slave bus_s,
  output logic  timer_irq_o
);

  soc_pkg::timer_word_u    mtime_q, mtimecmp_q;
  soc_pkg::axil_resp_e     bresp_q;
  logic [`AXIL_DATA_W-1:0] rdata_q, rd_word;
  logic rvalid_q, bvalid_q, rd_go, wr_go;

  assign rd_go = bus_s.arvalid && !rvalid_q;
  assign wr_go = bus_s.awvalid && bus_s.wvalid && !bvalid_q;

  assign bus_s.arready = !rvalid_q;
  assign bus_s.rdata   = rdata_q;
  assign bus_s.rresp   = soc_pkg::RESP_OKAY;
  assign bus_s.rvalid  = rvalid_q;
  assign bus_s.awready = wr_go;
  assign bus_s.wready  = wr_go;
  assign bus_s.bresp   = bresp_q;
  assign bus_s.bvalid  = bvalid_q;

  always_comb begin
    case (bus_s.araddr[3:2])
      2'd0:    rd_word = mtimecmp_q.half.lo;
      2'd1:    rd_word = mtimecmp_q.half.hi;
      2'd2:    rd_word = mtime_q.half.lo;
      default: rd_word = mtime_q.half.hi;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rvalid_q    <= 1'b0;
      bvalid_q    <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;  // far future, no irq
      timer_irq_o <= 1'b0;
    end else begin
      mtime_q.full <= mtime_q.full + 64'd1;
      timer_irq_o  <= mtime_q.full >= mtimecmp_q.full;
      if (rd_go) rvalid_q <= 1'b1;
      else if (bus_s.rready) rvalid_q <= 1'b0;
      if (wr_go) bvalid_q <= 1'b1;
      else if (bus_s.bready) bvalid_q <= 1'b0;
      if (wr_go && bus_s.awaddr[3:2] == 2'd0) mtimecmp_q.half.lo <= bus_s.wdata;
      if (wr_go && bus_s.awaddr[3:2] == 2'd1) mtimecmp_q.half.hi <= bus_s.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) rdata_q <= rd_word;
    // mtime is read only from the bus
    if (wr_go) bresp_q <= bus_s.awaddr[3] ? soc_pkg::RESP_SLVERR : soc_pkg::RESP_OKAY;
  end

endmodule

// File: design/soc_periph_top.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

module soc_periph_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`AXIL_ADDR_W-1:0] cpu_araddr_i,
  input  logic                    cpu_arvalid_i,
  output logic                    cpu_arready_o,
  output logic [`AXIL_DATA_W-1:0] cpu_rdata_o,
  output logic [1:0]              cpu_rresp_o,
  output logic                    cpu_rvalid_o,
  input  logic                    cpu_rready_i,
  input  logic [`AXIL_ADDR_W-1:0] cpu_awaddr_i,
  input  logic                    cpu_awvalid_i,
  output logic                    cpu_awready_o,
  input  logic [`AXIL_DATA_W-1:0] cpu_wdata_i,
  input  logic                    cpu_wvalid_i,
  output logic                    cpu_wready_o,
  output logic [1:0]              cpu_bresp_o,
  output logic                    cpu_bvalid_o,
  input  logic                    cpu_bready_i,
  output logic                    uart_tx_o,
  output logic                    timer_irq_o
);

  axil_if cpu_bus ();
  axil_if sram_bus ();
  axil_if uart_bus ();
  axil_if clint_bus ();

  // CPU side, plain ports onto the bus bundle
  assign cpu_bus.araddr  = cpu_araddr_i;
  assign cpu_bus.arvalid = cpu_arvalid_i;
  assign cpu_bus.rready  = cpu_rready_i;
  assign cpu_bus.awaddr  = cpu_awaddr_i;
  assign cpu_bus.awvalid = cpu_awvalid_i;
  assign cpu_bus.wdata   = cpu_wdata_i;
  assign cpu_bus.wvalid  = cpu_wvalid_i;
  assign cpu_bus.bready  = cpu_bready_i;
  assign cpu_arready_o   = cpu_bus.arready;
  assign cpu_rdata_o     = cpu_bus.rdata;
  assign cpu_rresp_o     = cpu_bus.rresp;
  assign cpu_rvalid_o    = cpu_bus.rvalid;
  assign cpu_awready_o   = cpu_bus.awready;
  assign cpu_wready_o    = cpu_bus.wready;
  assign cpu_bresp_o     = cpu_bus.bresp;
  assign cpu_bvalid_o    = cpu_bus.bvalid;

  axil_xbar u_xbar (
    .clk     (clk),
    .rst     (rst),
    .cpu_s   (cpu_bus.slave),
    .sram_m  (sram_bus.master),
    .uart_m  (uart_bus.master),
    .clint_m (clint_bus.master)
  );

  axil_sram u_sram (.clk(clk), .rst(rst), .bus_s(sram_bus.slave));

  axil_uart u_uart (.clk(clk), .rst(rst), .bus_s(uart_bus.slave), .uart_tx_o(uart_tx_o));

  axil_clint u_clint (
    .clk         (clk),
    .rst         (rst),
    .bus_s       (clint_bus.slave),
    .timer_irq_o (timer_irq_o)
  );

endmodule

// File: dv/tb_soc_periph.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

module tb_soc_periph;

  localparam int CLK_PERIOD   = 10;
  localparam int BIT_NS       = `UART_CLKS_PER_BIT * CLK_PERIOD;
  localparam int N_SRAM_OPS   = 60;
  localparam int N_ERR_OPS    = 8;
  localparam int N_UART_BYTES = 4;
  localparam int N_TICK_READS = 6;
  localparam int N_IRQ_ROUNDS = 3;
  localparam int IRQ_WAIT     = 60;  // cycles beyond the largest compare offset
  // worst case per bus operation with room for a whole UART frame
  localparam int OP_BUDGET    = 10 * `UART_CLKS_PER_BIT + 20;
  localparam int N_OPS = N_SRAM_OPS + 3 * N_ERR_OPS + 5 * N_UART_BYTES + N_TICK_READS + 4 +
                         8 * N_IRQ_ROUNDS;

  logic                    clk, rst;
  logic [`AXIL_ADDR_W-1:0] cpu_araddr_i, cpu_awaddr_i;
  logic [`AXIL_DATA_W-1:0] cpu_wdata_i, cpu_rdata_o;
  logic [1:0]              cpu_rresp_o, cpu_bresp_o;
  logic cpu_arvalid_i, cpu_arready_o, cpu_rvalid_o, cpu_rready_i;
  logic cpu_awvalid_i, cpu_awready_o, cpu_wvalid_i, cpu_wready_o;
  logic cpu_bvalid_o, cpu_bready_i, uart_tx_o, timer_irq_o;

  integer seed;
  logic [`AXIL_DATA_W-1:0] sram_model [int];  // byte offset -> last written word
  int     written[$];

  soc_periph_top dut0 (
    .clk(clk), .rst(rst),
    .cpu_araddr_i(cpu_araddr_i), .cpu_arvalid_i(cpu_arvalid_i), .cpu_arready_o(cpu_arready_o),
    .cpu_rdata_o(cpu_rdata_o), .cpu_rresp_o(cpu_rresp_o), .cpu_rvalid_o(cpu_rvalid_o),
    .cpu_rready_i(cpu_rready_i),
    .cpu_awaddr_i(cpu_awaddr_i), .cpu_awvalid_i(cpu_awvalid_i), .cpu_awready_o(cpu_awready_o),
    .cpu_wdata_i(cpu_wdata_i), .cpu_wvalid_i(cpu_wvalid_i), .cpu_wready_o(cpu_wready_o),
    .cpu_bresp_o(cpu_bresp_o), .cpu_bvalid_o(cpu_bvalid_o), .cpu_bready_i(cpu_bready_i),
    .uart_tx_o(uart_tx_o), .timer_irq_o(timer_irq_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_now(input string msg);
    $display("FAIL %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_resp(input string what, input soc_pkg::axil_resp_e got,
                            input soc_pkg::axil_resp_e exp);
    if (got !== exp)
      fail_now($sformatf("%s: resp %s (%0d), expected %s", what, got.name(), got, exp.name()));
  endtask

  task automatic check_data(input string what, input logic [`AXIL_DATA_W-1:0] got,
                            input logic [`AXIL_DATA_W-1:0] exp);
    if (got !== exp)
      fail_now($sformatf("%s: data 0x%08h, expected 0x%08h", what, got, exp));
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      fail_now($sformatf("uart frame: byte 0x%02h, expected 0x%02h", got, exp));
  endtask

  task automatic check_irq(input string what, input logic got, input logic exp);
    if (got !== exp)
      fail_now($sformatf("%s: timer_irq_o %b, expected %b", what, got, exp));
  endtask

  // all sampling happens at a falling edge before new inputs are driven
  task automatic axil_read(input logic [`AXIL_ADDR_W-1:0] addr,
                           output logic [`AXIL_DATA_W-1:0] data,
                           output soc_pkg::axil_resp_e resp);
    int stall;
    @(negedge clk);
    cpu_araddr_i  = addr;
    cpu_arvalid_i = 1'b1;
    @(negedge clk);
    while (cpu_arready_o !== 1'b1) @(negedge clk);
    @(negedge clk);  // AR beat went through on the rising edge
    cpu_arvalid_i = 1'b0;
    while (cpu_rvalid_o !== 1'b1) @(negedge clk);
    data  = cpu_rdata_o;
    resp  = soc_pkg::axil_resp_e'(cpu_rresp_o);
    stall = $unsigned($random(seed)) % 4;
    repeat (stall) begin
      @(negedge clk);
      if (cpu_rvalid_o !== 1'b1) fail_now("rvalid dropped while rready was held low");
      check_data("rdata under back-pressure", cpu_rdata_o, data);
      check_resp("rresp under back-pressure", soc_pkg::axil_resp_e'(cpu_rresp_o), resp);
    end
    cpu_rready_i = 1'b1;
    @(negedge clk);
    cpu_rready_i = 1'b0;
  endtask

  task automatic axil_write(input logic [`AXIL_ADDR_W-1:0] addr,
                            input logic [`AXIL_DATA_W-1:0] data,
                            output soc_pkg::axil_resp_e resp);
    int stall;
    @(negedge clk);
    cpu_awaddr_i  = addr;
    cpu_awvalid_i = 1'b1;
    cpu_wdata_i   = data;
    cpu_wvalid_i  = 1'b1;
    @(negedge clk);
    while (!(cpu_awready_o === 1'b1 && cpu_wready_o === 1'b1)) @(negedge clk);
    @(negedge clk);
    cpu_awvalid_i = 1'b0;
    cpu_wvalid_i  = 1'b0;
    while (cpu_bvalid_o !== 1'b1) @(negedge clk);
    resp  = soc_pkg::axil_resp_e'(cpu_bresp_o);
    stall = $unsigned($random(seed)) % 4;
    repeat (stall) begin
      @(negedge clk);
      if (cpu_bvalid_o !== 1'b1) fail_now("bvalid dropped while bready was held low");
      check_resp("bresp under back-pressure", soc_pkg::axil_resp_e'(cpu_bresp_o), resp);
    end
    cpu_bready_i = 1'b1;
    @(negedge clk);
    cpu_bready_i = 1'b0;
  endtask

  function automatic logic is_mapped(input logic [`AXIL_ADDR_W-1:0] a);
    return (a >= `SRAM_BASE && a < `SRAM_END) || (a >= `UART_BASE && a < `UART_END) ||
           (a >= `CLINT_BASE && a < `CLINT_END);
  endfunction

  task automatic run_sram_test();
    int i, off;
    logic [`AXIL_DATA_W-1:0] data;
    soc_pkg::axil_resp_e resp;
    for (i = 0; i < N_SRAM_OPS; i++) begin
      if (written.size() == 0 || ($random(seed) & 1)) begin
        off  = ($unsigned($random(seed)) % `SRAM_DEPTH_WORDS) * 4;
        data = $random(seed);
        axil_write(`SRAM_BASE + off, data, resp);
        check_resp("sram write", resp, soc_pkg::RESP_OKAY);
        sram_model[off] = data;
        written.push_back(off);
      end else begin
        off = written[$unsigned($random(seed)) % written.size()];  // only known words
        axil_read(`SRAM_BASE + off, data, resp);
        check_resp("sram read", resp, soc_pkg::RESP_OKAY);
        check_data($sformatf("sram read at offset 0x%03h", off), data, sram_model[off]);
      end
    end
  endtask

  task automatic run_decerr_test();
    int i;
    logic [11:0] probe_off;
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`AXIL_DATA_W-1:0] data;
    soc_pkg::axil_resp_e resp;
    probe_off = 12'(written[0]);
    for (i = 0; i < N_ERR_OPS; i++) begin
      // low bits alias the probed SRAM word so a leaked write would show up
      addr = $random(seed);
      addr[11:0] = probe_off;
      while (is_mapped(addr)) begin
        addr = $random(seed);
        addr[11:0] = probe_off;
      end
      axil_read(addr, data, resp);
      check_resp("unmapped read", resp, soc_pkg::RESP_DECERR);
      check_data("unmapped read", data, '0);
      axil_write(addr, $random(seed), resp);
      check_resp("unmapped write", resp, soc_pkg::RESP_DECERR);
      axil_read(`SRAM_BASE + written[0], data, resp);  // nothing leaked into the SRAM
      check_resp("sram read after decerr", resp, soc_pkg::RESP_OKAY);
      check_data("sram read after decerr", data, sram_model[written[0]]);
    end
  endtask

  task automatic capture_frame(output logic [7:0] b);
    int k;
    @(negedge uart_tx_o);
    #(BIT_NS / 2);
    if (uart_tx_o !== 1'b0) fail_now("uart start bit was not low at mid-bit");
    for (k = 0; k < 8; k++) begin
      #(BIT_NS);
      b[k] = uart_tx_o;  // LSB first
    end
    #(BIT_NS);
    if (uart_tx_o !== 1'b1) fail_now("uart stop bit was not high at mid-bit");
  endtask

  task automatic run_uart_test();
    int i;
    logic [7:0] tx_byte, rx_byte;
    logic [`AXIL_DATA_W-1:0] data;
    soc_pkg::axil_resp_e resp;
    for (i = 0; i < N_UART_BYTES; i++) begin
      tx_byte = $random(seed);
      fork
        capture_frame(rx_byte);
        begin
          axil_write(`UART_BASE, {24'h0, tx_byte}, resp);
          check_resp("uart txdata write", resp, soc_pkg::RESP_OKAY);
          axil_read(`UART_BASE + 4, data, resp);
          check_resp("uart status read", resp, soc_pkg::RESP_OKAY);
          check_data("uart status during frame", data, 32'h1);
          axil_write(`UART_BASE, {24'h0, ~tx_byte}, resp);
          check_resp("uart txdata write while busy", resp, soc_pkg::RESP_SLVERR);
        end
      join
      check_byte(rx_byte, tx_byte);
      repeat (`UART_CLKS_PER_BIT) @(negedge clk);  // rest of the stop bit
      axil_read(`UART_BASE + 4, data, resp);
      check_data("uart status after frame", data, 32'h0);
      if (uart_tx_o !== 1'b1) fail_now("uart line not idle high after frame");
    end
  endtask

  task automatic run_mtime_test();
    int i;
    logic [`AXIL_DATA_W-1:0] prev, cur;
    soc_pkg::axil_resp_e resp;
    axil_read(`CLINT_BASE + 8, prev, resp);
    check_resp("mtime lo read", resp, soc_pkg::RESP_OKAY);
    for (i = 0; i <= N_TICK_READS; i++) begin
      if (i == N_TICK_READS) begin
        axil_write(`CLINT_BASE + 8, 32'h0, resp);
        check_resp("mtime lo write", resp, soc_pkg::RESP_SLVERR);
        axil_write(`CLINT_BASE + 12, 32'h0, resp);
        check_resp("mtime hi write", resp, soc_pkg::RESP_SLVERR);
      end
      axil_read(`CLINT_BASE + 8, cur, resp);
      if (cur <= prev) fail_now($sformatf("mtime lo 0x%08h not above 0x%08h", cur, prev));
      prev = cur;
    end
  endtask

  task automatic read_mtime(output soc_pkg::timer_word_u t);
    soc_pkg::axil_resp_e resp;
    axil_read(`CLINT_BASE + 8, t.half.lo, resp);
    axil_read(`CLINT_BASE + 12, t.half.hi, resp);
  endtask

  task automatic run_irq_test();
    int i, n;
    soc_pkg::timer_word_u now_w, cmp_w, seen_w;
    soc_pkg::axil_resp_e resp;
    for (i = 0; i < N_IRQ_ROUNDS; i++) begin
      check_irq("before compare write", timer_irq_o, 1'b0);
      read_mtime(now_w);
      cmp_w.full = now_w.full + 64'd20 + 64'($unsigned($random(seed)) % 31);
      axil_write(`CLINT_BASE, cmp_w.half.lo, resp);  // hi still all ones
      check_resp("mtimecmp lo write", resp, soc_pkg::RESP_OKAY);
      axil_write(`CLINT_BASE + 4, cmp_w.half.hi, resp);
      check_resp("mtimecmp hi write", resp, soc_pkg::RESP_OKAY);
      n = 0;
      while (timer_irq_o !== 1'b1 && n < IRQ_WAIT) begin
        @(negedge clk);
        n++;
      end
      check_irq("after compare reached", timer_irq_o, 1'b1);
      read_mtime(seen_w);
      if (seen_w.full < cmp_w.full)
        fail_now($sformatf("irq high with mtime 0x%016h below 0x%016h", seen_w.full, cmp_w.full));
      axil_write(`CLINT_BASE + 4, 32'hffff_ffff, resp);
      check_resp("mtimecmp hi clear", resp, soc_pkg::RESP_OKAY);
      check_irq("after compare pushed out", timer_irq_o, 1'b0);
    end
  endtask

  initial begin
    #(N_OPS * OP_BUDGET * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d clock cycles", N_OPS * OP_BUDGET);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    seed          = 26823;
    clk           = 1'b0;
    rst           = 1'b0;
    cpu_araddr_i  = '0;
    cpu_arvalid_i = 1'b0;
    cpu_rready_i  = 1'b0;
    cpu_awaddr_i  = '0;
    cpu_awvalid_i = 1'b0;
    cpu_wdata_i   = '0;
    cpu_wvalid_i  = 1'b0;
    cpu_bready_i  = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b1;
    check_irq("after reset", timer_irq_o, 1'b0);
    if (uart_tx_o !== 1'b1) fail_now("uart_tx_o not high after reset");
    run_sram_test();
    run_decerr_test();
    run_uart_test();
    run_mtime_test();
    run_irq_test();
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+design
design/soc_pkg.sv
design/axil_if.sv
design/axil_xbar.sv
design/axil_sram.sv
design/axil_uart.sv
design/axil_clint.sv
design/soc_periph_top.sv
dv/tb_soc_periph.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_periph
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(filter-out +%,$(shell cat sources.f))
HDRS := $(wildcard design/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): sources.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sources.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
